//--- compile.f
hw/tileGenPkg.sv
hw/videoIfs.sv
hw/beamCounter.sv
hw/scrollLayer.sv
hw/addrSequencer.sv
hw/tilemapAddrGen.sv
verif/tileGenClock.sv
verif/tilemapAddrGenTb.sv

//--- hw/addrSequencer.sv
`timescale 1ns/1ns

module addrSequencer (
	input logic CLK_6M,
	input logic rst,
	input logic clk2H,
	input tileGenPkg::cpuDataT rd,
	beamIf.seqSide beam,
	layerIf.seqSide layerA,
	layerIf.seqSide layerB,
	output tileGenPkg::ramAddrT ra,
	output tileGenPkg::promAddrT ga,
	output logic ha2,
	output logic hb2
);

	////////////////////////////////////////
	// layer select
	////////////////////////////////////////

	// high when layer B is active
	logic selB;
	tileGenPkg::tileRowT selRow;
	tileGenPkg::tileColT selCol;
	logic [2:0] selFineRow;
	logic selNibble;
	// byte select, aligned with the layer positions
	logic hBit0Q;
	// captured ram bytes
	tileGenPkg::tileIndexT tileIndex;
	tileGenPkg::tileAttrT tileAttr;

	// 2H low picks layer B
	assign selB = !clk2H;
	assign selRow = selB ? layerB.tileRow : layerA.tileRow;
	assign selCol = selB ? layerB.tileCol : layerA.tileCol;
	assign selFineRow = selB ? layerB.fineRow : layerA.fineRow;
	assign selNibble = selB ? layerB.nibble : layerA.nibble;

	// pixel phase, delayed to match hPos
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hBit0Q <= 1'b0;
		end else begin
			hBit0Q <= beam.hCount[0];
		end
	end

	////////////////////////////////////////
	// ram and prom addresses
	////////////////////////////////////////

	// ram: layer, row, column, byte
	// prom: attr, index, fine row, nibble
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			ra <= '0;
			ga <= '0;
		end else begin
			ra <= {selB, selRow, selCol, hBit0Q};
			// bytes from the previous fetch
			ga <= {tileAttr, tileIndex, selFineRow, selNibble};
		end
	end

	// even byte is the tile number, odd byte the attributes
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			tileIndex <= '0;
			tileAttr <= '0;
		end else if (!ra[0]) begin
			tileIndex <= rd;
		end else begin
			// only the low two attribute bits reach the prom
			tileAttr <= rd[1:0];
		end
	end

	////////////////////////////////////////
	// 4-pixel strobes
	////////////////////////////////////////

	// high on every 4th scrolled pixel of each layer
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			ha2 <= 1'b0;
			hb2 <= 1'b0;
		end else begin
			ha2 <= (layerA.hPos[1:0] == 2'b00);
			hb2 <= (layerB.hPos[1:0] == 2'b00);
		end
	end

endmodule

//--- hw/beamCounter.sv
`timescale 1ns/1ns

module beamCounter (
	input logic CLK_6M,
	input logic rst,
	input logic nHsync,
	input logic nVsync,
	beamIf.counterSide beam
);

	////////////////////////////////////////
	// sync edge detect
	////////////////////////////////////////

	// last sync samples, syncs idle high
	logic hsyncLast;
	logic vsyncLast;
	// falling edges seen at this clock
	logic hsyncFall;
	logic vsyncFall;

	assign hsyncFall = !nHsync && hsyncLast;
	assign vsyncFall = !nVsync && vsyncLast;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hsyncLast <= 1'b1;
			vsyncLast <= 1'b1;
		end else begin
			hsyncLast <= nHsync;
			vsyncLast <= nVsync;
		end
	end

	////////////////////////////////////////
	// beam counters
	////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			beam.hCount <= '0;
			beam.vCount <= '0;
			beam.lineStart <= 1'b0;
			beam.frameStart <= 1'b0;
		end else begin
			// pulses line up with the counter reload
			beam.lineStart <= hsyncFall;
			beam.frameStart <= hsyncFall && vsyncFall;
			if (hsyncFall) begin
				beam.hCount <= '0;
				// vertical only moves on line boundaries
				if (vsyncFall) begin
					beam.vCount <= '0;
				end else begin
					beam.vCount <= beam.vCount + 9'd1;
				end
			end else begin
				// free running, wraps at 512
				beam.hCount <= beam.hCount + 9'd1;
			end
		end
	end

endmodule

//--- hw/scrollLayer.sv
`timescale 1ns/1ns

module scrollLayer #(
	parameter int layerIdx = 0,
	parameter int autoscroll = 0
) (
	input logic CLK_6M,
	input logic rst,
	input logic flip,
	input logic nLatch,
	input tileGenPkg::regSelT ca,
	input tileGenPkg::cpuDataT cd,
	beamIf.layerSide beam,
	layerIf.layerSide pos
);

	////////////////////////////////////////
	// cpu scroll registers
	////////////////////////////////////////

	// latched offsets
	tileGenPkg::scrollT hScroll;
	tileGenPkg::vScrollT vScroll;
	// write decode
	logic layerHit;
	logic hLowWrite;
	logic hHighWrite;
	logic vWrite;
	// once per frame
	logic frameEdge;
	// beam position after flip
	tileGenPkg::hCountT hBeam;
	tileGenPkg::vCountT vBeam;

	// only writes aimed at this layer
	assign layerHit = !nLatch && (ca[2] == 1'(layerIdx));
	assign hLowWrite = layerHit && (ca[1:0] == 2'b00);
	assign hHighWrite = layerHit && (ca[1:0] == 2'b01);
	// select 11 falls through, nothing latched
	assign vWrite = layerHit && (ca[1:0] == 2'b10);

	// frame pulse only comes together with a line pulse
	assign frameEdge = beam.lineStart && beam.frameStart;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hScroll <= '0;
			vScroll <= '0;
		end else begin
			// cpu write beats the autoscroll step
			if (hLowWrite) begin
				hScroll[7:0] <= cd;
			end else if (hHighWrite) begin
				hScroll[8] <= cd[0];
			end else if (frameEdge) begin
				hScroll <= hScroll + tileGenPkg::scrollT'(autoscroll);
			end
			if (vWrite) begin
				vScroll <= cd;
			end
		end
	end

	////////////////////////////////////////
	// scrolled position
	////////////////////////////////////////

	// flipped screen counts backwards
	assign hBeam = flip ? ~beam.hCount : beam.hCount;
	assign vBeam = flip ? ~beam.vCount : beam.vCount;

	// one stage behind the beam, wraps at 9 bits
	always_ff @(posedge CLK_6M) begin
		pos.hPos <= hScroll + hBeam;
		pos.vPos <= tileGenPkg::scrollT'(vScroll) + vBeam;
	end

	// tilemap cell and position inside the tile
	assign pos.tileCol = pos.hPos[8:3];
	assign pos.nibble = pos.hPos[2];
	// 32 rows, bit 8 drops out
	assign pos.tileRow = pos.vPos[7:3];
	assign pos.fineRow = pos.vPos[2:0];

endmodule

//--- hw/tileGenPkg.sv
package tileGenPkg;

	////////////////////////////////////////
	// layer count
	////////////////////////////////////////

	// two scroll layers, A is layer 0 and B is layer 1
	parameter int numLayers = 2;

	////////////////////////////////////////
	// beam and scroll widths
	////////////////////////////////////////

	// horizontal beam position, one line wraps inside 9 bits
	typedef logic [8:0] hCountT;
	// vertical beam position
	typedef logic [8:0] vCountT;
	// scrolled position or horizontal offset
	typedef logic [8:0] scrollT;
	// vertical offset has no 9th bit
	typedef logic [7:0] vScrollT;

	////////////////////////////////////////
	// tilemap and graphics fields
	////////////////////////////////////////

	// 64 columns x 32 rows per layer
	typedef logic [5:0] tileColT;
	typedef logic [4:0] tileRowT;
	// tile number, first byte of an entry
	typedef logic [7:0] tileIndexT;
	// low attribute bits, from the second byte
	typedef logic [1:0] tileAttrT;
	// layer, row, column, byte
	typedef logic [12:0] ramAddrT;
	// attr, index, fine row, nibble
	typedef logic [13:0] promAddrT;
	// cpu data bus byte, also used for ram data
	typedef logic [7:0] cpuDataT;
	// bit 2 picks the layer, bits 1:0 the register
	typedef logic [2:0] regSelT;

endpackage

//--- hw/tilemapAddrGen.sv
`timescale 1ns/1ns

module tilemapAddrGen #(
	parameter int layerAAutoscroll = 0,
	parameter int layerBAutoscroll = 0
) (
	input logic CLK_6M,
	input logic rst,
	input logic clk2H,
	input logic nHsync,
	input logic nVsync,
	input logic flip,
	input logic nLatch,
	input tileGenPkg::regSelT ca,
	input tileGenPkg::cpuDataT cd,
	input tileGenPkg::cpuDataT rd,
	output tileGenPkg::ramAddrT ra,
	output tileGenPkg::promAddrT ga,
	output logic ha2,
	output logic hb2
);

	////////////////////////////////////////
	// internal buses
	////////////////////////////////////////

	// beam position, one driver
	beamIf beamBus ();
	// index 0 is layer A, index 1 layer B
	layerIf layerBus [tileGenPkg::numLayers] ();

	// sync inputs to screen position
	beamCounter beamCounter_i (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.nHsync(nHsync),
		.nVsync(nVsync),
		.beam(beamBus)
	);

	////////////////////////////////////////
	// scroll layers
	////////////////////////////////////////

	for (genvar i = 0; i < tileGenPkg::numLayers; i++) begin : layerGen
		// each layer gets its own autoscroll step
		scrollLayer #(
			.layerIdx(i),
			.autoscroll((i == 0) ? layerAAutoscroll : layerBAutoscroll)
		) scrollLayer_i (
			.CLK_6M(CLK_6M),
			.rst(rst),
			.flip(flip),
			.nLatch(nLatch),
			.ca(ca),
			.cd(cd),
			.beam(beamBus),
			.pos(layerBus[i])
		);
	end

	// address assembly, layers interleaved by 2H
	addrSequencer addrSequencer_i (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.clk2H(clk2H),
		.rd(rd),
		.beam(beamBus),
		.layerA(layerBus[0]),
		.layerB(layerBus[1]),
		.ra(ra),
		.ga(ga),
		.ha2(ha2),
		.hb2(hb2)
	);

endmodule

//--- hw/videoIfs.sv
`timescale 1ns/1ns

// beam position shared by the layers and the sequencer
interface beamIf;
	tileGenPkg::hCountT hCount;
	tileGenPkg::vCountT vCount;
	// one cycle pulses
	logic lineStart;
	logic frameStart;

	modport counterSide(output hCount, output vCount, output lineStart, output frameStart);
	modport layerSide(input hCount, input vCount, input lineStart, input frameStart);
	// sequencer only needs the pixel phase
	modport seqSide(input hCount);
endinterface

// scrolled position of one layer, split into tilemap fields
interface layerIf;
	tileGenPkg::scrollT hPos;
	tileGenPkg::scrollT vPos;
	tileGenPkg::tileColT tileCol;
	tileGenPkg::tileRowT tileRow;
	// row inside the 8x8 tile
	logic [2:0] fineRow;
	// 4-pixel half of the tile row
	logic nibble;

	modport layerSide(output hPos, output vPos, output tileCol, output tileRow,
		output fineRow, output nibble);
	modport seqSide(input hPos, input vPos, input tileCol, input tileRow,
		input fineRow, input nibble);
endinterface

//--- run.sh
#!/usr/bin/env bash
# build the tilemap testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found"
	exit 1
fi

verilator --binary --timing --timescale 1ns/1ns -f compile.f \
	--top-module tilemapAddrGenTb -Mdir obj_dir -o tilemapAddrGenTb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed"
	exit $status
fi

./obj_dir/tilemapAddrGenTb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi
exit 0

//--- verif/tileGenClock.sv
`timescale 1ns/1ns

module tileGenClock #(
	parameter int periodNs = 20,
	parameter int resetCycles = 4
) (
	output logic CLK_6M,
	output logic rst
);

	// free running pixel clock
	initial begin
		CLK_6M = 1'b0;
		forever #(periodNs / 2) CLK_6M = ~CLK_6M;
	end

	// reset held over the first edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge CLK_6M);
		@(negedge CLK_6M);
		rst = 1'b0;
	end

endmodule

//--- verif/tilemapAddrGenTb.sv
`timescale 1ns/1ns

module tilemapAddrGenTb;

	////////////////////////////////////////
	// video timing and run length
	////////////////////////////////////////

	localparam int clkPeriodNs = 20;
	localparam int clocksPerLine = 384;
	localparam int hsyncClocks = 32;
	localparam int linesPerFrame = 16;
	localparam int vsyncLines = 2;
	localparam int autoA = 3;
	localparam int autoB = 5;
	// 2 unscrolled, 3 cpu writes, 4 autoscroll, 3 flip
	localparam int totalFrames = 12;
	localparam int watchdogNs = 2 * totalFrames * linesPerFrame * clocksPerLine * clkPeriodNs;

	logic CLK_6M;
	logic rst;
	logic clk2H;
	logic nHsync;
	logic nVsync;
	logic flip;
	logic nLatch;
	tileGenPkg::regSelT ca;
	tileGenPkg::cpuDataT cd;
	tileGenPkg::cpuDataT rd;
	tileGenPkg::ramAddrT ra;
	tileGenPkg::promAddrT ga;
	logic ha2;
	logic hb2;
	// 8K tilemap ram contents
	tileGenPkg::cpuDataT ramModel [8192];
	logic [1:0] phase2H;

	// reference model state
	logic mHsLast;
	logic mVsLast;
	tileGenPkg::hCountT mH;
	tileGenPkg::vCountT mV;
	logic mFrame;
	tileGenPkg::scrollT mHScroll [tileGenPkg::numLayers];
	tileGenPkg::vScrollT mVScroll [tileGenPkg::numLayers];
	tileGenPkg::scrollT mHPos [tileGenPkg::numLayers];
	tileGenPkg::scrollT mVPos [tileGenPkg::numLayers];
	logic mHBit0Q;
	tileGenPkg::ramAddrT mRa;
	tileGenPkg::promAddrT mGa;
	tileGenPkg::tileIndexT mIdx;
	tileGenPkg::tileAttrT mAttr;
	logic mHa2;
	logic mHb2;

	tileGenClock #(.periodNs(clkPeriodNs), .resetCycles(4)) tileGenClock_i (
		.CLK_6M(CLK_6M),
		.rst(rst)
	);

	tilemapAddrGen #(.layerAAutoscroll(autoA), .layerBAutoscroll(autoB)) tilemapAddrGen_i (
		.CLK_6M(CLK_6M), .rst(rst), .clk2H(clk2H), .nHsync(nHsync), .nVsync(nVsync),
		.flip(flip), .nLatch(nLatch), .ca(ca), .cd(cd), .rd(rd),
		.ra(ra), .ga(ga), .ha2(ha2), .hb2(hb2)
	);

	////////////////////////////////////////
	// reference model, one step per edge
	////////////////////////////////////////

	// sequencer reads the layer positions from before this edge
	task automatic stepSequencer();
		logic sel;
		// layer B while 2H is low
		sel = !clk2H;
		if (rst) begin
			mRa = '0;
			mGa = '0;
			mIdx = '0;
			mAttr = '0;
			mHa2 = 1'b0;
			mHb2 = 1'b0;
			mHBit0Q = 1'b0;
		end else begin
			// ga still carries the bytes from before this capture
			mGa = {mAttr, mIdx, mVPos[sel][2:0], mHPos[sel][2]};
			if (mRa[0]) begin
				mAttr = rd[1:0];
			end else begin
				mIdx = rd;
			end
			mRa = {sel, mVPos[sel][7:3], mHPos[sel][8:3], mHBit0Q};
			mHa2 = (mHPos[1'b0][1:0] == 2'b00);
			mHb2 = (mHPos[1'b1][1:0] == 2'b00);
			mHBit0Q = mH[0];
		end
	endtask

	task automatic stepLayer(input logic l);
		logic hit;
		tileGenPkg::hCountT hBeam;
		tileGenPkg::vCountT vBeam;
		hit = !nLatch && (ca[2] == l);
		hBeam = flip ? ~mH : mH;
		vBeam = flip ? ~mV : mV;
		// position lags offsets and beam by one edge
		mHPos[l] = mHScroll[l] + hBeam;
		mVPos[l] = tileGenPkg::scrollT'(mVScroll[l]) + vBeam;
		if (rst) begin
			mHScroll[l] = '0;
			mVScroll[l] = '0;
		end else begin
			// a write in the frame start cycle replaces the autoscroll step
			if (hit && ca[1:0] == 2'b00) begin
				mHScroll[l][7:0] = cd;
			end else if (hit && ca[1:0] == 2'b01) begin
				mHScroll[l][8] = cd[0];
			end else if (mFrame) begin
				mHScroll[l] = mHScroll[l] + tileGenPkg::scrollT'(l ? autoB : autoA);
			end
			if (hit && ca[1:0] == 2'b10) begin
				mVScroll[l] = cd;
			end
		end
	endtask

	task automatic stepBeam();
		logic hFall;
		logic vFall;
		hFall = !nHsync && mHsLast;
		vFall = !nVsync && mVsLast;
		if (rst) begin
			mHsLast = 1'b1;
			mVsLast = 1'b1;
			mH = '0;
			mV = '0;
			mFrame = 1'b0;
		end else begin
			mFrame = hFall && vFall;
			if (hFall) begin
				mH = '0;
				if (vFall) begin
					mV = '0;
				end else begin
					mV = mV + 9'd1;
				end
			end else begin
				mH = mH + 9'd1;
			end
			mHsLast = nHsync;
			mVsLast = nVsync;
		end
	endtask

	always @(posedge CLK_6M) begin
		stepSequencer();
		stepLayer(1'b0);
		stepLayer(1'b1);
		stepBeam();
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	task automatic failRun(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkRa(input string testName, input tileGenPkg::ramAddrT expected,
		input tileGenPkg::ramAddrT actual);
		if (actual !== expected) begin
			failRun($sformatf("Fail %s ra expected %h actual %h", testName, expected, actual));
		end
	endtask

	task automatic checkGa(input string testName, input tileGenPkg::promAddrT expected,
		input tileGenPkg::promAddrT actual);
		if (actual !== expected) begin
			failRun($sformatf("Fail %s ga expected %h actual %h", testName, expected, actual));
		end
	endtask

	task automatic checkStrobe(input string testName, input string strobe, input logic expected,
		input logic actual);
		if (actual !== expected) begin
			failRun($sformatf("Fail %s %s expected %b actual %b", testName, strobe, expected,
				actual));
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	// one pass per clock, outputs checked before inputs move
	task automatic runFrames(input string testName, input int frames, input bit randomWrites,
		input bit frameWrites, input bit randomFlip);
		for (int f = 0; f < frames; f++) begin
			for (int line = 0; line < linesPerFrame; line++) begin
				for (int hPhase = 0; hPhase < clocksPerLine; hPhase++) begin
					@(negedge CLK_6M);
					checkRa(testName, mRa, ra);
					checkGa(testName, mGa, ga);
					checkStrobe(testName, "ha2", mHa2, ha2);
					checkStrobe(testName, "hb2", mHb2, hb2);
					// ram answers the address now on the bus
					rd = ramModel[ra];
					phase2H = phase2H + 2'd1;
					clk2H = phase2H[1];
					// vsync falls together with hsync at line 0
					nHsync = (hPhase >= hsyncClocks);
					nVsync = (line >= vsyncLines);
					nLatch = 1'b1;
					if (randomWrites && $urandom_range(0, 15) == 0) begin
						nLatch = 1'b0;
						ca = tileGenPkg::regSelT'($urandom);
						cd = tileGenPkg::cpuDataT'($urandom);
					end
					// lands on the edge that sees frameStart
					if (frameWrites && f > 0 && line == 0 && hPhase == 1) begin
						nLatch = 1'b0;
						ca = (f % 2 == 1) ? 3'b000 : 3'b101;
						cd = tileGenPkg::cpuDataT'($urandom);
					end
					if (randomFlip && line == 0 && hPhase == 0) begin
						flip = (f == 0) ? 1'b1 : 1'($urandom);
					end
				end
			end
		end
	endtask

	initial begin
		void'($urandom(9686));
		clk2H = 1'b0;
		nHsync = 1'b1;
		nVsync = 1'b1;
		flip = 1'b0;
		nLatch = 1'b1;
		ca = '0;
		cd = '0;
		rd = '0;
		phase2H = 2'b00;
		for (int i = 0; i < 8192; i++) begin
			ramModel[tileGenPkg::ramAddrT'(i)] = tileGenPkg::cpuDataT'($urandom);
		end
		@(negedge rst);
		runFrames("unscrolled", 2, 1'b0, 1'b0, 1'b0);
		runFrames("cpuWrites", 3, 1'b1, 1'b0, 1'b0);
		runFrames("autoscroll", 4, 1'b0, 1'b1, 1'b0);
		runFrames("flip", 3, 1'b0, 1'b0, 1'b1);
		$display("NO ERRORS");
		$finish;
	end

	// twice the length of all frames
	initial begin
		#(watchdogNs);
		failRun("the run timed out before all frames were done");
	end

endmodule
